/* compile.f */
design/alu_pkg.sv
design/cla_pkg.sv
design/cla16.sv
design/adder64.sv
design/alu_issue.sv
design/alu_core.sv
design/alu_writeback.sv
design/alu_top.sv
sim/alu_tb.sv

/* Bender.yml */
package:
  name: alu_exec

sources:
  - design/alu_pkg.sv
  - design/cla_pkg.sv
  - design/cla16.sv
  - design/adder64.sv
  - design/alu_issue.sv
  - design/alu_core.sv
  - design/alu_writeback.sv
  - design/alu_top.sv
  - target: test
    files:
      - sim/alu_tb.sv

/* sim/alu_tb.sv */
/*
 * Testbench for the integer execute stage
 * Reference model, expected-value queue, directed and random stimulus
 * Concurrent assertions on reset, valid timing, result and carry
 */

`default_nettype none

module alu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import alu_pkg::*;

    // Directed operations plus random slots with idles
    localparam int n_directed = 67;
    localparam int n_random   = 200;
    localparam int n_ops      = n_directed + n_random;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    alu_op_e         in_op;
    logic [xlen-1:0] in_a;
    logic [xlen-1:0] in_b;
    logic            out_valid;
    logic [xlen-1:0] out_result;
    logic            out_carry;

    logic [xlen:0]   exp_q[$];
    logic [xlen-1:0] exp_result;
    logic            exp_carry;
    int              value_errors;
    int              other_errors;

    alu_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_a       (in_a),
        .in_b       (in_b),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_carry  (out_carry)
    );

    always #10 clk = ~clk;

    function automatic logic [xlen-1:0] sign_extend_word(input logic [word_w-1:0] w);
        return {{word_w{w[word_w-1]}}, w};
    endfunction

    // Expected {carry, result} from the RV64I rules
    function automatic logic [xlen:0] model(input alu_op_e op, input logic [xlen-1:0] a,
                                            input logic [xlen-1:0] b);
        logic [word_w-1:0] w;
        case (op)
            op_add:  return {1'b0, a} + {1'b0, b};
            // Carry set when no borrow
            op_sub:  return {a >= b, a - b};
            op_addw: w = a[31:0] + b[31:0];
            op_subw: w = a[31:0] - b[31:0];
            op_sll:  return {1'b0, a << b[5:0]};
            op_srl:  return {1'b0, a >> b[5:0]};
            op_sra:  return {1'b0, $signed(a) >>> b[5:0]};
            op_sllw: w = a[31:0] << b[4:0];
            op_srlw: w = a[31:0] >> b[4:0];
            op_sraw: w = $signed(a[31:0]) >>> b[4:0];
            op_slt:  return {64'd0, $signed(a) < $signed(b)};
            op_sltu: return {64'd0, a < b};
            op_and:  return {1'b0, a & b};
            op_or:   return {1'b0, a | b};
            default: return {1'b0, a ^ b};
        endcase
        return {1'b0, sign_extend_word(w)};
    endfunction

    function automatic logic [xlen-1:0] rand64();
        return {$urandom, $urandom};
    endfunction

    task automatic issue(input alu_op_e op, input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        @(posedge clk);
        in_valid <= 1'b1;
        in_op    <= op;
        in_a     <= a;
        in_b     <= b;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Scoreboard pushes on issue and pops on completion
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (in_valid) begin
            exp_q.push_back(model(in_op, in_a, in_b));
        end
        if (out_valid && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
    end

    // Oldest outstanding operation held stable for the next rising edge
    always @(negedge clk) begin
        if (exp_q.size() > 0) begin
            exp_result = exp_q[0][xlen-1:0];
            exp_carry  = exp_q[0][xlen];
        end
    end

    assert property (@(posedge clk) (!rst_n || !$past(rst_n))
                     |-> (!out_valid && out_result == '0 && !out_carry))
        else begin
            value_errors++;
            $display("mismatch reset outputs out_valid %h out_result %h out_carry %h",
                     $sampled(out_valid), $sampled(out_result), $sampled(out_carry));
        end

    assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> $past(in_valid, 2))
        else begin
            other_errors++;
            $display("out_valid pulse with no operation issued at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n) $past(in_valid, 2) |-> out_valid)
        else begin
            other_errors++;
            $display("out_valid missing two edges after an issued operation at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> out_result == exp_result)
        else begin
            value_errors++;
            $display("mismatch out_result expected %h actual %h",
                     $sampled(exp_result), $sampled(out_result));
        end

    assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> out_carry == exp_carry)
        else begin
            value_errors++;
            $display("mismatch out_carry expected %h actual %h",
                     $sampled(exp_carry), $sampled(out_carry));
        end

    initial begin
        #((n_ops + 20) * 20);
        other_errors++;
        $display("timeout, operations did not drain in time");
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        logic [xlen-1:0] x;
        logic [xlen-1:0] pa [7];
        logic [xlen-1:0] pb [7];
        int              amounts [5];

        void'($urandom(5268));
        clk          = 1'b0;
        rst_n        = 1'b1;
        in_valid     = 1'b0;
        in_op        = op_add;
        in_a         = '0;
        in_b         = '0;
        value_errors = 0;
        other_errors = 0;
        // Reset edge after time zero
        #1 rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Carry across each 16-bit block boundary
        x = rand64();
        issue(op_add, {64{1'b1}}, 64'd1);
        issue(op_add, 64'h0000_FFFF_FFFF_FFFF, 64'd1);
        issue(op_add, 64'h0000_0000_FFFF_FFFF, 64'd1);
        issue(op_add, 64'h0000_0000_0000_FFFF, 64'd1);
        issue(op_sub, x, x);
        issue(op_sub, 64'd0, 64'd1);
        idle_cycle();

        // Shifts with random noise in the upper bits of b
        amounts = '{0, 31, 32, 63, $urandom_range(63, 0)};
        for (int op_i = 4; op_i <= 9; op_i++) begin
            foreach (amounts[j]) begin
                issue(alu_op_e'(op_i), rand64(), (rand64() & ~64'h3F) | amounts[j]);
            end
        end
        idle_cycle();

        for (int op_i = 2; op_i <= 3; op_i++) begin
            issue(alu_op_e'(op_i), 64'hFFFF_FFFF_7FFF_FFFF, 64'd1);
            repeat (3) issue(alu_op_e'(op_i), rand64(), rand64());
        end
        idle_cycle();

        // Mixed-sign compare pairs
        pa = '{64'h8000_0000_0000_0000, 64'd0, {64{1'b1}}, 64'd1, 64'd5, rand64(), rand64()};
        pb = '{64'd0, 64'h8000_0000_0000_0000, 64'd1, {64{1'b1}}, 64'd5, rand64(), rand64()};
        for (int op_i = 10; op_i <= 11; op_i++) begin
            foreach (pa[j]) begin
                issue(alu_op_e'(op_i), pa[j], pb[j]);
            end
        end
        for (int op_i = 12; op_i <= 14; op_i++) begin
            repeat (3) issue(alu_op_e'(op_i), rand64(), rand64());
        end
        idle_cycle();

        // Random mix with gaps and back-to-back bursts
        repeat (n_random) begin
            if ($urandom_range(3, 0) != 0) begin
                issue(alu_op_e'($urandom_range(14, 0)), rand64(), rand64());
            end else begin
                idle_cycle();
            end
        end
        idle_cycle();

        @(negedge clk);
        while (exp_q.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/alu_top.sv */
/*
 * Integer execute stage top level
 * Issue register, ALU core and writeback register
 */

`default_nettype none

module alu_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  alu_pkg::alu_op_e         in_op,
    input  logic [alu_pkg::xlen-1:0] in_a,
    input  logic [alu_pkg::xlen-1:0] in_b,
    output logic                     out_valid,
    output logic [alu_pkg::xlen-1:0] out_result,
    output logic                     out_carry
);
    import alu_pkg::*;

    logic            iss_valid;
    alu_op_e         iss_op;
    logic [xlen-1:0] iss_a;
    logic [xlen-1:0] iss_b;
    logic [xlen-1:0] core_result;
    logic            core_carry;

    alu_issue u_alu_issue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_a      (in_a),
        .in_b      (in_b),
        .iss_valid (iss_valid),
        .iss_op    (iss_op),
        .iss_a     (iss_a),
        .iss_b     (iss_b)
    );

    alu_core u_alu_core (
        .op     (iss_op),
        .a      (iss_a),
        .b      (iss_b),
        .result (core_result),
        .carry  (core_carry)
    );

    alu_writeback u_alu_writeback (
        .clk         (clk),
        .rst_n       (rst_n),
        .iss_valid   (iss_valid),
        .iss_op      (iss_op),
        .core_result (core_result),
        .core_carry  (core_carry),
        .out_valid   (out_valid),
        .out_result  (out_result),
        .out_carry   (out_carry)
    );

endmodule

`default_nettype wire

/* design/alu_writeback.sv */
/*
 * Writeback register of the execute stage
 * Word-op sign extension, result, carry and valid pulse
 */

`default_nettype none

module alu_writeback (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     iss_valid,
    input  alu_pkg::alu_op_e         iss_op,
    input  logic [alu_pkg::xlen-1:0] core_result,
    input  logic                     core_carry,
    output logic                     out_valid,
    output logic [alu_pkg::xlen-1:0] out_result,
    output logic                     out_carry
);
    import alu_pkg::*;

    logic            is_word;
    logic [xlen-1:0] wb_result;

    assign is_word = (iss_op == op_addw) || (iss_op == op_subw) || (iss_op == op_sllw)
                  || (iss_op == op_srlw) || (iss_op == op_sraw);

    // RV64 W ops sign-extend from bit 31
    assign wb_result = is_word ? {{word_w{core_result[word_w-1]}}, core_result[word_w-1:0]}
                               : core_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            out_result <= '0;
            out_carry  <= 1'b0;
        end else begin
            out_valid <= iss_valid;
            if (iss_valid) begin
                out_result <= wb_result;
                out_carry  <= core_carry;
            end
        end
    end

endmodule

`default_nettype wire

/* design/alu_core.sv */
/*
 * Combinational ALU core
 * Lookahead add/sub, barrel shifts, logic ops and set-less-than
 */

`default_nettype none

module alu_core (
    input  alu_pkg::alu_op_e         op,
    input  logic [alu_pkg::xlen-1:0] a,
    input  logic [alu_pkg::xlen-1:0] b,
    output logic [alu_pkg::xlen-1:0] result,
    output logic                     carry
);
    import alu_pkg::*;

    logic                     sub;
    logic [xlen-1:0]          sum;
    logic                     cout;
    logic                     lt_signed;
    logic [shamt_w-1:0]       shamt;
    logic [shamt_word_w-1:0]  shamt_word;
    logic [word_w-1:0]        a_word;
    logic signed [xlen-1:0]   a_sext;

    // Compares reuse the subtractor
    assign sub = (op == op_sub) || (op == op_subw) || (op == op_slt) || (op == op_sltu);

    adder64 u_adder64 (
        .a    (a),
        .b    (b),
        .sub  (sub),
        .sum  (sum),
        .cout (cout)
    );

    // Operand signs differ, a is less if it is negative
    assign lt_signed = (a[xlen-1] != b[xlen-1]) ? a[xlen-1] : sum[xlen-1];

    assign shamt      = b[shamt_w-1:0];
    assign shamt_word = b[shamt_word_w-1:0];
    assign a_word     = a[word_w-1:0];
    assign a_sext     = {{word_w{a[word_w-1]}}, a_word};

    // ------------------------------------------------------------------------
    // Result select, word results are raw in the low half
    // ------------------------------------------------------------------------
    always_comb begin
        result = '0;
        case (op)
            op_add, op_sub, op_addw, op_subw: result = sum;
            op_sll:  result = a << shamt;
            op_srl:  result = a >> shamt;
            op_sra:  result = $signed(a) >>> shamt;
            op_sllw: result = {{word_w{1'b0}}, a_word << shamt_word};
            op_srlw: result = {{word_w{1'b0}}, a_word >> shamt_word};
            op_sraw: result = a_sext >>> shamt_word;
            op_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
            // Borrow means a below b
            op_sltu: result = {{(xlen-1){1'b0}}, ~cout};
            op_and:  result = a & b;
            op_or:   result = a | b;
            op_xor:  result = a ^ b;
            default: result = '0;
        endcase
    end

    // Carry only reported for full-width add and subtract
    assign carry = ((op == op_add) || (op == op_sub)) ? cout : 1'b0;

endmodule

`default_nettype wire

/* design/alu_issue.sv */
/*
 * Issue register of the execute stage
 * Captures valid strobe, opcode and both operands
 */

`default_nettype none

module alu_issue (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  alu_pkg::alu_op_e         in_op,
    input  logic [alu_pkg::xlen-1:0] in_a,
    input  logic [alu_pkg::xlen-1:0] in_b,
    output logic                     iss_valid,
    output alu_pkg::alu_op_e         iss_op,
    output logic [alu_pkg::xlen-1:0] iss_a,
    output logic [alu_pkg::xlen-1:0] iss_b
);
    import alu_pkg::*;

    // Valid strobe, sampled every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= in_valid;
        end
    end

    // Operation payload, held while idle
    always_ff @(posedge clk) begin
        if (in_valid) begin
            iss_op <= in_op;
            iss_a  <= in_a;
            iss_b  <= in_b;
        end
    end

endmodule

`default_nettype wire

/* design/adder64.sv */
/*
 * 64-bit adder/subtractor
 * Four cla16 blocks chained through their carries
 */

`default_nettype none

module adder64 (
    input  logic [63:0] a,
    input  logic [63:0] b,
    input  logic        sub,
    output logic [63:0] sum,
    output logic        cout
);
    import cla_pkg::*;

    logic [63:0]         b_in;
    logic [cla_blocks:0] c;

    genvar k;

    // Two's complement, invert b and add one through carry-in
    assign b_in = sub ? ~b : b;
    assign c[0] = sub;

    // Block k carry-out feeds block k+1
    for (k = 0; k < cla_blocks; k++) begin : g_blk
        cla16 u_cla16 (
            .a    (a[k*cla_block_w +: cla_block_w]),
            .b    (b_in[k*cla_block_w +: cla_block_w]),
            .cin  (c[k]),
            .sum  (sum[k*cla_block_w +: cla_block_w]),
            .cout (c[k+1])
        );
    end

    assign cout = c[cla_blocks];

endmodule

`default_nettype wire

/* design/cla16.sv */
/*
 * 16-bit carry-lookahead adder
 * Four 4-bit generate/propagate groups with a second-level lookahead
 */

`default_nettype none

module cla16 (
    input  logic [cla_pkg::cla_block_w-1:0] a,
    input  logic [cla_pkg::cla_block_w-1:0] b,
    input  logic                            cin,
    output logic [cla_pkg::cla_block_w-1:0] sum,
    output logic                            cout
);
    import cla_pkg::*;

    logic [cla_block_w-1:0]             g;
    logic [cla_block_w-1:0]             p;
    logic [cla_block_w-1:0]             c;
    logic [cla_block_w/cla_group_w-1:0] grp_g;
    logic [cla_block_w/cla_group_w-1:0] grp_p;
    logic [cla_block_w/cla_group_w:0]   grp_c;

    genvar i;

    // Bit generate and propagate
    assign g = a & b;
    assign p = a ^ b;

    // ------------------------------------------------------------------------
    // First level, carries inside each group from the group carry-in
    // ------------------------------------------------------------------------
    for (i = 0; i < cla_block_w / cla_group_w; i++) begin : g_grp
        logic [cla_group_w-1:0] gg;
        logic [cla_group_w-1:0] pp;
        logic [cla_group_w-1:0] cc;

        assign gg = g[i*cla_group_w +: cla_group_w];
        assign pp = p[i*cla_group_w +: cla_group_w];

        assign cc[0] = grp_c[i];
        assign cc[1] = gg[0] | (pp[0] & grp_c[i]);
        assign cc[2] = gg[1] | (pp[1] & gg[0]) | (pp[1] & pp[0] & grp_c[i]);
        assign cc[3] = gg[2] | (pp[2] & gg[1]) | (pp[2] & pp[1] & gg[0])
                     | (pp[2] & pp[1] & pp[0] & grp_c[i]);

        assign c[i*cla_group_w +: cla_group_w] = cc;

        // Group terms seen by the second level
        assign grp_g[i] = gg[3] | (pp[3] & gg[2]) | (pp[3] & pp[2] & gg[1])
                        | (pp[3] & pp[2] & pp[1] & gg[0]);
        assign grp_p[i] = &pp;
    end

    // ------------------------------------------------------------------------
    // Second level, group carries straight from cin
    // ------------------------------------------------------------------------
    assign grp_c[0] = cin;
    assign grp_c[1] = grp_g[0] | (grp_p[0] & cin);
    assign grp_c[2] = grp_g[1] | (grp_p[1] & grp_g[0]) | (grp_p[1] & grp_p[0] & cin);
    assign grp_c[3] = grp_g[2] | (grp_p[2] & grp_g[1]) | (grp_p[2] & grp_p[1] & grp_g[0])
                    | (grp_p[2] & grp_p[1] & grp_p[0] & cin);
    assign grp_c[4] = grp_g[3] | (grp_p[3] & grp_g[2]) | (grp_p[3] & grp_p[2] & grp_g[1])
                    | (grp_p[3] & grp_p[2] & grp_p[1] & grp_g[0])
                    | (&grp_p & cin);

    assign sum  = p ^ c;
    assign cout = grp_c[4];

endmodule

`default_nettype wire

/* design/cla_pkg.sv */
/*
 * Carry-lookahead adder geometry
 * Block width, group width and block count of the 64-bit adder
 */

`default_nettype none

package cla_pkg;

    // One cla16 block is four 4-bit groups
    localparam int cla_block_w = 16;
    localparam int cla_group_w = 4;

    // Blocks chained by carry in the 64-bit adder
    localparam int cla_blocks  = 4;

endpackage

`default_nettype wire

/* design/alu_pkg.sv */
/*
 * Datapath widths for the RV64I integer execute stage
 * ALU opcode enumeration shared by issue, core and writeback
 */

`default_nettype none

package alu_pkg;

    // Register and shift widths
    localparam int xlen         = 64;
    localparam int shamt_w      = 6;
    localparam int shamt_word_w = 5;
    localparam int word_w       = 32;

    // ALU operations, W suffix works on the low word
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_addw = 4'd2,
        op_subw = 4'd3,
        op_sll  = 4'd4,
        op_srl  = 4'd5,
        op_sra  = 4'd6,
        op_sllw = 4'd7,
        op_srlw = 4'd8,
        op_sraw = 4'd9,
        op_slt  = 4'd10,
        op_sltu = 4'd11,
        op_and  = 4'd12,
        op_or   = 4'd13,
        op_xor  = 4'd14
    } alu_op_e;

endpackage

`default_nettype wire
